/* logic/hwce_settings.svh */
////////////////////////////////////////////////////////////////////////////
// width and depth settings of the convolution engine wrapper
// include wherever a bus width, the FIFO depth or the word step is needed
////////////////////////////////////////////////////////////////////////////

`ifndef HWCE_SETTINGS_SVH
`define HWCE_SETTINGS_SVH

// memory side
`define HWCE_ADDR_W 32
`define HWCE_DATA_W 32
`define HWCE_WORD_BYTES 4

// configuration side, the address is a word index into the register map
`define HWCE_ID_W 8
`define HWCE_CFG_ADDR_W 3

// job sizing
`define HWCE_LEN_W 16
`define HWCE_FIFO_DEPTH 4

`endif

/* logic/hwce_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// shared types of the convolution engine wrapper
// memory and configuration buses, the programmed job, register map and
// the state encodings; imported by the RTL and the testbench
////////////////////////////////////////////////////////////////////////////

`include "hwce_settings.svh"

package hwce_pkg;

  typedef struct packed {
    logic                    req;
    logic                    we;
    logic [`HWCE_ADDR_W-1:0] addr;
    logic [`HWCE_DATA_W-1:0] wdata;
  } tcdm_req_t;

  typedef struct packed {
    logic                    gnt;
    logic                    r_valid;
    logic [`HWCE_DATA_W-1:0] r_data;
  } tcdm_rsp_t;

  typedef struct packed {
    logic                        req;
    logic                        we;
    logic [`HWCE_CFG_ADDR_W-1:0] addr;
    logic [`HWCE_DATA_W-1:0]     wdata;
    logic [`HWCE_ID_W-1:0]       id;
  } cfg_req_t;

  typedef struct packed {
    logic                    r_valid;
    logic [`HWCE_DATA_W-1:0] r_data;
    logic [`HWCE_ID_W-1:0]   r_id;
  } cfg_rsp_t;

  typedef struct packed {
    logic [`HWCE_ADDR_W-1:0] src_base;
    logic [`HWCE_ADDR_W-1:0] dst_base;
    logic [`HWCE_LEN_W-1:0]  len;
    logic [`HWCE_ADDR_W-1:0] wgt_base;
    logic [`HWCE_LEN_W-1:0]  wgt_len;
  } job_cfg_t;

  typedef enum logic [1:0] {JOB_IDLE, JOB_WEIGHTS, JOB_STREAM, JOB_DONE} job_state_e;

  // register map, word indices
  typedef enum logic [`HWCE_CFG_ADDR_W-1:0] {
    REG_TRIGGER  = 0,
    REG_STATUS   = 1,
    REG_SRC_BASE = 2,
    REG_DST_BASE = 3,
    REG_LEN      = 4,
    REG_WGT_BASE = 5,
    REG_WGT_LEN  = 6
  } cfg_reg_e;

  typedef enum logic [1:0] {OWN_NONE, OWN_SOURCE, OWN_SINK, OWN_WEIGHTS} arb_owner_e;

endpackage

/* logic/hwce_job_ctrl.sv */
////////////////////////////////////////////////////////////////////////////
// configuration slave and job sequencer
// holds the register map, answers every access one cycle later, runs the
// weight phase and then the stream phase and pulses evt_o at job end
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "hwce_settings.svh"

module hwce_job_ctrl import hwce_pkg::*; (
  input  logic     clk_gated,
  input  logic     rst_n,
  input  cfg_req_t cfg_i,
  output cfg_rsp_t cfg_o,
  output job_cfg_t job_o,
  output logic     wgt_start_o,
  output logic     stream_start_o,
  input  logic     wgt_done_i,
  input  logic     src_done_i,
  input  logic     snk_done_i,
  output logic     busy_o,
  output logic     evt_o
);

  job_state_e              state_q;
  job_cfg_t                job_q;
  logic                    src_done_q;
  logic                    snk_done_q;
  logic                    src_seen;
  logic                    snk_seen;
  logic                    cfg_wr;
  logic                    trigger;
  logic [`HWCE_DATA_W-1:0] rd_data;
  logic                    rsp_valid_q;
  logic [`HWCE_DATA_W-1:0] rsp_data_q;
  logic [`HWCE_ID_W-1:0]   rsp_id_q;

  assign busy_o  = (state_q == JOB_WEIGHTS) || (state_q == JOB_STREAM);
  assign evt_o   = (state_q == JOB_DONE);
  assign job_o   = job_q;
  // register writes only land while no job runs
  assign cfg_wr  = cfg_i.req && cfg_i.we && !busy_o;
  assign trigger = cfg_wr && (cfg_reg_e'(cfg_i.addr) == REG_TRIGGER);

  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      job_q <= '0;
    end else if (cfg_wr) begin
      case (cfg_reg_e'(cfg_i.addr))
        REG_SRC_BASE: job_q.src_base <= cfg_i.wdata;
        REG_DST_BASE: job_q.dst_base <= cfg_i.wdata;
        REG_LEN:      job_q.len      <= cfg_i.wdata[`HWCE_LEN_W-1:0];
        REG_WGT_BASE: job_q.wgt_base <= cfg_i.wdata;
        REG_WGT_LEN:  job_q.wgt_len  <= cfg_i.wdata[`HWCE_LEN_W-1:0];
        default: ;
      endcase
    end
  end

  always_comb begin
    case (cfg_reg_e'(cfg_i.addr))
      REG_STATUS:   rd_data = `HWCE_DATA_W'(busy_o);
      REG_SRC_BASE: rd_data = job_q.src_base;
      REG_DST_BASE: rd_data = job_q.dst_base;
      REG_LEN:      rd_data = `HWCE_DATA_W'(job_q.len);
      REG_WGT_BASE: rd_data = job_q.wgt_base;
      REG_WGT_LEN:  rd_data = `HWCE_DATA_W'(job_q.wgt_len);
      default:      rd_data = '0;
    endcase
  end

  // reply one cycle after every request, reads and writes alike
  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= cfg_i.req;
    end
  end

  always_ff @(posedge clk_gated) begin
    if (cfg_i.req) begin
      rsp_data_q <= rd_data;
      rsp_id_q   <= cfg_i.id;
    end
  end

  assign cfg_o = '{r_valid: rsp_valid_q, r_data: rsp_data_q, r_id: rsp_id_q};

  // a done pulse counts whether it arrives now or was latched before
  assign src_seen = src_done_q || src_done_i;
  assign snk_seen = snk_done_q || snk_done_i;

  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      state_q        <= JOB_IDLE;
      wgt_start_o    <= 1'b0;
      stream_start_o <= 1'b0;
      src_done_q     <= 1'b0;
      snk_done_q     <= 1'b0;
    end else begin
      wgt_start_o    <= 1'b0;
      stream_start_o <= 1'b0;
      case (state_q)
        JOB_IDLE, JOB_DONE: begin
          state_q <= JOB_IDLE;
          if (trigger && job_q.wgt_len != '0) begin
            state_q     <= JOB_WEIGHTS;
            wgt_start_o <= 1'b1;
          end else if (trigger) begin
            state_q        <= JOB_STREAM;
            stream_start_o <= 1'b1;
          end
        end
        JOB_WEIGHTS: begin
          if (wgt_done_i) begin
            state_q        <= JOB_STREAM;
            stream_start_o <= 1'b1;
          end
        end
        JOB_STREAM: begin
          src_done_q <= src_seen;
          snk_done_q <= snk_seen;
          if (src_seen && snk_seen) begin
            state_q    <= JOB_DONE;
            src_done_q <= 1'b0;
            snk_done_q <= 1'b0;
          end
        end
        default: state_q <= JOB_IDLE;
      endcase
    end
  end

endmodule

/* logic/hwce_weight_loader.sv */
////////////////////////////////////////////////////////////////////////////
// weight loader
// reads wgt_len words from wgt_base and strobes every returned word with
// its index; done comes with the last response
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "hwce_settings.svh"

module hwce_weight_loader import hwce_pkg::*; (
  input  logic                    clk_gated,
  input  logic                    rst_n,
  input  job_cfg_t                job_i,
  input  logic                    start_i,
  output tcdm_req_t               mem_o,
  input  tcdm_rsp_t               mem_i,
  output logic                    wgt_valid_o,
  output logic [`HWCE_DATA_W-1:0] wgt_data_o,
  output logic [`HWCE_LEN_W-1:0]  wgt_idx_o,
  output logic                    done_o
);

  logic                   active_q;
  logic [`HWCE_LEN_W-1:0] iss_cnt_q;
  logic [`HWCE_LEN_W-1:0] rsp_cnt_q;

  assign mem_o.req   = active_q && (iss_cnt_q != job_i.wgt_len);
  assign mem_o.we    = 1'b0;
  assign mem_o.addr  = job_i.wgt_base + iss_cnt_q * `HWCE_WORD_BYTES;
  assign mem_o.wdata = '0;

  // responses come back in order, so the response count is the index
  assign wgt_valid_o = mem_i.r_valid;
  assign wgt_data_o  = mem_i.r_data;
  assign wgt_idx_o   = rsp_cnt_q;
  assign done_o      = mem_i.r_valid && (rsp_cnt_q == job_i.wgt_len - 1'b1);

  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      active_q  <= 1'b0;
      iss_cnt_q <= '0;
      rsp_cnt_q <= '0;
    end else if (start_i) begin
      active_q  <= 1'b1;
      iss_cnt_q <= '0;
      rsp_cnt_q <= '0;
    end else begin
      if (mem_o.req && mem_i.gnt) begin
        iss_cnt_q <= iss_cnt_q + 1'b1;
      end
      if (mem_i.r_valid) begin
        rsp_cnt_q <= rsp_cnt_q + 1'b1;
      end
      if (done_o) begin
        active_q <= 1'b0;
      end
    end
  end

endmodule

/* logic/hwce_stream_source.sv */
////////////////////////////////////////////////////////////////////////////
// memory to stream source
// reads len words from src_base into a small FIFO and drains it onto the
// output stream; done pulses with the last stream transfer
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "hwce_settings.svh"

module hwce_stream_source import hwce_pkg::*; (
  input  logic                    clk_gated,
  input  logic                    rst_n,
  input  job_cfg_t                job_i,
  input  logic                    start_i,
  output tcdm_req_t               mem_o,
  input  tcdm_rsp_t               mem_i,
  output logic [`HWCE_DATA_W-1:0] out_data_o,
  output logic                    out_valid_o,
  input  logic                    out_ready_i,
  output logic                    done_o
);

  localparam int PTR_W = $clog2(`HWCE_FIFO_DEPTH);

  logic                    active_q;
  logic                    inflight_q;
  logic [`HWCE_LEN_W-1:0]  iss_cnt_q;
  logic [`HWCE_LEN_W-1:0]  xfer_cnt_q;
  logic [PTR_W-1:0]        wr_ptr_q;
  logic [PTR_W-1:0]        rd_ptr_q;
  logic [PTR_W:0]          fill_q;
  logic [`HWCE_DATA_W-1:0] fifo_mem [`HWCE_FIFO_DEPTH];
  logic                    room;
  logic                    push;
  logic                    pop;

  // a word in flight already owns a FIFO slot
  assign room = (int'(fill_q) + int'(inflight_q)) < `HWCE_FIFO_DEPTH;

  assign mem_o.req   = active_q && (iss_cnt_q != job_i.len) && room;
  assign mem_o.we    = 1'b0;
  assign mem_o.addr  = job_i.src_base + iss_cnt_q * `HWCE_WORD_BYTES;
  assign mem_o.wdata = '0;

  assign push        = mem_i.r_valid;
  assign pop         = out_valid_o && out_ready_i;
  assign out_valid_o = (fill_q != '0);
  assign out_data_o  = fifo_mem[rd_ptr_q];
  assign done_o      = pop && (xfer_cnt_q == job_i.len - 1'b1);

  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      active_q   <= 1'b0;
      inflight_q <= 1'b0;
      iss_cnt_q  <= '0;
      xfer_cnt_q <= '0;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fill_q     <= '0;
    end else begin
      inflight_q <= mem_o.req && mem_i.gnt;
      if (start_i) begin
        active_q   <= 1'b1;
        iss_cnt_q  <= '0;
        xfer_cnt_q <= '0;
      end else begin
        if (mem_o.req && mem_i.gnt) begin
          iss_cnt_q <= iss_cnt_q + 1'b1;
        end
        if (pop) begin
          xfer_cnt_q <= xfer_cnt_q + 1'b1;
        end
        if (done_o) begin
          active_q <= 1'b0;
        end
      end
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   fill_q <= fill_q + 1'b1;
        2'b01:   fill_q <= fill_q - 1'b1;
        default: fill_q <= fill_q;
      endcase
    end
  end

  always_ff @(posedge clk_gated) begin
    if (push) begin
      fifo_mem[wr_ptr_q] <= mem_i.r_data;
    end
  end

endmodule

/* logic/hwce_stream_sink.sv */
////////////////////////////////////////////////////////////////////////////
// stream to memory sink
// takes one input word at a time into a holding register and writes it to
// dst_base plus the word offset; done pulses when the len-th write is granted
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "hwce_settings.svh"

module hwce_stream_sink import hwce_pkg::*; (
  input  logic                    clk_gated,
  input  logic                    rst_n,
  input  job_cfg_t                job_i,
  input  logic                    start_i,
  input  logic [`HWCE_DATA_W-1:0] in_data_i,
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  output tcdm_req_t               mem_o,
  input  tcdm_rsp_t               mem_i,
  output logic                    done_o
);

  logic                    active_q;
  logic                    hold_vld_q;
  logic [`HWCE_LEN_W-1:0]  wr_cnt_q;
  logic [`HWCE_DATA_W-1:0] hold_data_q;

  // no new word while the held one waits for the memory
  assign in_ready_o = active_q && !hold_vld_q;

  assign mem_o.req   = hold_vld_q;
  assign mem_o.we    = 1'b1;
  assign mem_o.addr  = job_i.dst_base + wr_cnt_q * `HWCE_WORD_BYTES;
  assign mem_o.wdata = hold_data_q;

  assign done_o = mem_i.gnt && (wr_cnt_q == job_i.len - 1'b1);

  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      active_q   <= 1'b0;
      hold_vld_q <= 1'b0;
      wr_cnt_q   <= '0;
    end else if (start_i) begin
      active_q   <= 1'b1;
      hold_vld_q <= 1'b0;
      wr_cnt_q   <= '0;
    end else begin
      if (in_valid_i && in_ready_o) begin
        hold_vld_q <= 1'b1;
      end else if (mem_i.gnt) begin
        hold_vld_q <= 1'b0;
        wr_cnt_q   <= wr_cnt_q + 1'b1;
      end
      if (done_o) begin
        active_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_gated) begin
    if (in_valid_i && in_ready_o) begin
      hold_data_q <= in_data_i;
    end
  end

endmodule

/* logic/hwce_tcdm_arbiter.sv */
////////////////////////////////////////////////////////////////////////////
// round-robin share of the single TCDM port
// peers in order weights, source, sink; the read owner is registered at
// grant so r_valid goes back to that peer only
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module hwce_tcdm_arbiter import hwce_pkg::*; (
  input  logic      clk_gated,
  input  logic      rst_n,
  input  tcdm_req_t wgt_req_i,
  output tcdm_rsp_t wgt_rsp_o,
  input  tcdm_req_t src_req_i,
  output tcdm_rsp_t src_rsp_o,
  input  tcdm_req_t snk_req_i,
  output tcdm_rsp_t snk_rsp_o,
  output tcdm_req_t mem_req_o,
  input  tcdm_rsp_t mem_rsp_i
);

  localparam int NP = 3;
  localparam arb_owner_e PEER_OWN [NP] = '{OWN_WEIGHTS, OWN_SOURCE, OWN_SINK};

  tcdm_req_t  peer_req [NP];
  tcdm_rsp_t  peer_rsp [NP];
  logic [1:0] last_q;
  logic [1:0] sel_idx;
  logic       sel_vld;
  arb_owner_e owner_q;
  arb_owner_e pend_q;
  arb_owner_e lock;

  assign peer_req[0] = wgt_req_i;
  assign peer_req[1] = src_req_i;
  assign peer_req[2] = snk_req_i;
  assign wgt_rsp_o   = peer_rsp[0];
  assign src_rsp_o   = peer_rsp[1];
  assign snk_rsp_o   = peer_rsp[2];

  // an outstanding read or a request stalled on gnt keeps the port locked
  assign lock = (owner_q != OWN_NONE) ? owner_q : pend_q;

  always_comb begin
    int idx;
    sel_vld = 1'b0;
    sel_idx = '0;
    for (int i = 1; i <= NP; i++) begin
      idx = (int'(last_q) + i) % NP;
      if (!sel_vld && peer_req[idx].req && (lock == OWN_NONE || lock == PEER_OWN[idx])) begin
        sel_vld = 1'b1;
        sel_idx = 2'(idx);
      end
    end
  end

  assign mem_req_o = sel_vld ? peer_req[sel_idx] : '0;

  always_comb begin
    for (int i = 0; i < NP; i++) begin
      peer_rsp[i].gnt     = mem_rsp_i.gnt && sel_vld && (sel_idx == 2'(i));
      peer_rsp[i].r_valid = mem_rsp_i.r_valid && (owner_q == PEER_OWN[i]);
      peer_rsp[i].r_data  = mem_rsp_i.r_data;
    end
  end

  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      // start from the sink so the weights come first
      last_q  <= 2'd2;
      owner_q <= OWN_NONE;
      pend_q  <= OWN_NONE;
    end else if (mem_req_o.req && mem_rsp_i.gnt) begin
      last_q  <= sel_idx;
      owner_q <= mem_req_o.we ? OWN_NONE : PEER_OWN[sel_idx];
      pend_q  <= OWN_NONE;
    end else begin
      owner_q <= OWN_NONE;
      pend_q  <= sel_vld ? PEER_OWN[sel_idx] : OWN_NONE;
    end
  end

endmodule

/* logic/hwce_top.sv */
////////////////////////////////////////////////////////////////////////////
// convolution engine wrapper top level
// job controller, weight loader, stream source and sink around one shared
// TCDM master port
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "hwce_settings.svh"

module hwce_top import hwce_pkg::*; (
  input  logic                    clk_gated,
  input  logic                    rst_n,
  input  cfg_req_t                cfg_i,
  output cfg_rsp_t                cfg_o,
  output tcdm_req_t               mem_req_o,
  input  tcdm_rsp_t               mem_rsp_i,
  output logic [`HWCE_DATA_W-1:0] out_data_o,
  output logic                    out_valid_o,
  input  logic                    out_ready_i,
  input  logic [`HWCE_DATA_W-1:0] in_data_i,
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  output logic                    wgt_valid_o,
  output logic [`HWCE_DATA_W-1:0] wgt_data_o,
  output logic [`HWCE_LEN_W-1:0]  wgt_idx_o,
  output logic                    busy_o,
  output logic                    evt_o
);

  job_cfg_t  job;
  logic      wgt_start;
  logic      stream_start;
  logic      wgt_done;
  logic      src_done;
  logic      snk_done;
  tcdm_req_t wgt_req;
  tcdm_rsp_t wgt_rsp;
  tcdm_req_t src_req;
  tcdm_rsp_t src_rsp;
  tcdm_req_t snk_req;
  tcdm_rsp_t snk_rsp;

  hwce_job_ctrl i_job_ctrl (
    .clk_gated      (clk_gated),
    .rst_n          (rst_n),
    .cfg_i          (cfg_i),
    .cfg_o          (cfg_o),
    .job_o          (job),
    .wgt_start_o    (wgt_start),
    .stream_start_o (stream_start),
    .wgt_done_i     (wgt_done),
    .src_done_i     (src_done),
    .snk_done_i     (snk_done),
    .busy_o         (busy_o),
    .evt_o          (evt_o)
  );

  hwce_weight_loader i_weight_loader (
    .clk_gated   (clk_gated),
    .rst_n       (rst_n),
    .job_i       (job),
    .start_i     (wgt_start),
    .mem_o       (wgt_req),
    .mem_i       (wgt_rsp),
    .wgt_valid_o (wgt_valid_o),
    .wgt_data_o  (wgt_data_o),
    .wgt_idx_o   (wgt_idx_o),
    .done_o      (wgt_done)
  );

  hwce_stream_source i_stream_source (
    .clk_gated   (clk_gated),
    .rst_n       (rst_n),
    .job_i       (job),
    .start_i     (stream_start),
    .mem_o       (src_req),
    .mem_i       (src_rsp),
    .out_data_o  (out_data_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .done_o      (src_done)
  );

  hwce_stream_sink i_stream_sink (
    .clk_gated  (clk_gated),
    .rst_n      (rst_n),
    .job_i      (job),
    .start_i    (stream_start),
    .in_data_i  (in_data_i),
    .in_valid_i (in_valid_i),
    .in_ready_o (in_ready_o),
    .mem_o      (snk_req),
    .mem_i      (snk_rsp),
    .done_o     (snk_done)
  );

  hwce_tcdm_arbiter i_tcdm_arbiter (
    .clk_gated (clk_gated),
    .rst_n     (rst_n),
    .wgt_req_i (wgt_req),
    .wgt_rsp_o (wgt_rsp),
    .src_req_i (src_req),
    .src_rsp_o (src_rsp),
    .snk_req_i (snk_req),
    .snk_rsp_o (snk_rsp),
    .mem_req_o (mem_req_o),
    .mem_rsp_i (mem_rsp_i)
  );

endmodule

/* tests/hwce_checker.sv */
////////////////////////////////////////////////////////////////////////////
// protocol assertions on the top-level ports of the wrapper
// bound into hwce_top; failures show up as assertion errors
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module hwce_checker import hwce_pkg::*; (
  input logic      clk_gated,
  input logic      rst_n,
  input cfg_req_t  cfg_i,
  input cfg_rsp_t  cfg_o,
  input tcdm_req_t mem_req_o,
  input tcdm_rsp_t mem_rsp_i,
  input logic      evt_o
);

  int unsigned fail_cnt = 0;

  // job event is a single-cycle pulse
  evt_pulse: assert property (@(posedge clk_gated) disable iff (!rst_n) evt_o |=> !evt_o)
    else begin
      $error("evt_o stayed high for more than one cycle");
      fail_cnt++;
    end

  // read data only in the cycle after an accepted read
  mem_rvalid: assert property (@(posedge clk_gated) disable iff (!rst_n)
      mem_rsp_i.r_valid |-> $past(mem_req_o.req && mem_rsp_i.gnt && !mem_req_o.we))
    else begin
      $error("memory r_valid without an accepted read one cycle before");
      fail_cnt++;
    end

  cfg_reply: assert property (@(posedge clk_gated) disable iff (!rst_n)
      cfg_i.req |=> cfg_o.r_valid)
    else begin
      $error("no configuration reply one cycle after a request");
      fail_cnt++;
    end

  cfg_no_extra: assert property (@(posedge clk_gated) disable iff (!rst_n)
      cfg_o.r_valid |-> $past(cfg_i.req))
    else begin
      $error("configuration reply without a request one cycle before");
      fail_cnt++;
    end

endmodule

bind hwce_top hwce_checker i_checker (
  .clk_gated (clk_gated),
  .rst_n     (rst_n),
  .cfg_i     (cfg_i),
  .cfg_o     (cfg_o),
  .mem_req_o (mem_req_o),
  .mem_rsp_i (mem_rsp_i),
  .evt_o     (evt_o)
);

/* tests/hwce_tb.sv */
////////////////////////////////////////////////////////////////////////////
// testbench of the convolution engine wrapper
// random jobs from a fixed seed against a memory model with random grants,
// checked against a model of registers, weights, output stream and writes
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "hwce_settings.svh"

module hwce_tb import hwce_pkg::*; ();

  localparam int N_JOBS   = 8;
  localparam int WAIT_MAX = 3000;

  typedef logic [`HWCE_DATA_W-1:0] word_t;
  typedef logic [`HWCE_ADDR_W-1:0] addr_t;
  typedef logic [`HWCE_LEN_W-1:0]  idx_t;

  logic      clk_gated;
  logic      rst_n;
  cfg_req_t  cfg_i;
  cfg_rsp_t  cfg_o;
  tcdm_req_t mem_req_o;
  tcdm_rsp_t mem_rsp_i;
  word_t     out_data_o;
  logic      out_valid_o;
  logic      out_ready_i;
  word_t     in_data_i;
  logic      in_valid_i;
  logic      in_ready_o;
  logic      wgt_valid_o;
  word_t     wgt_data_o;
  idx_t      wgt_idx_o;
  logic      busy_o;
  logic      evt_o;

  // memory contents written by the DUT, everything else reads the fill pattern
  word_t mem_model [addr_t];
  word_t shadow [8];
  word_t exp_out [$];
  word_t exp_wgt [$];
  word_t in_words [$];
  int    in_idx;
  int    wgt_cnt;
  int    evt_cnt;
  logic  in_took;
  logic  rd_pend;
  addr_t rd_addr;
  addr_t dst_lo;
  addr_t dst_hi;
  logic  stall_out;
  logic  job_busy;

  hwce_top i_dut (
    .clk_gated   (clk_gated),
    .rst_n       (rst_n),
    .cfg_i       (cfg_i),
    .cfg_o       (cfg_o),
    .mem_req_o   (mem_req_o),
    .mem_rsp_i   (mem_rsp_i),
    .out_data_o  (out_data_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .in_data_i   (in_data_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .wgt_valid_o (wgt_valid_o),
    .wgt_data_o  (wgt_data_o),
    .wgt_idx_o   (wgt_idx_o),
    .busy_o      (busy_o),
    .evt_o       (evt_o)
  );

  initial begin
    clk_gated = 1'b0;
    forever begin
      #4 clk_gated = ~clk_gated;
    end
  end

  function automatic word_t fill_word(addr_t addr);
    return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
  endfunction

  function automatic word_t mem_read(addr_t addr);
    if (mem_model.exists(addr)) begin
      return mem_model[addr];
    end
    return fill_word(addr);
  endfunction

  task automatic stop_on_error(string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_cfg_rsp(cfg_rsp_t got, cfg_rsp_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("CHECK FAILED at %0t: cfg_o got %h expected %h",
                              $time, got, exp));
    end
  endtask

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                              $time, name, got, exp));
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      stop_on_error($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
                              $time, name, got, exp));
    end
  endtask

  task automatic check_weight(idx_t got_idx, word_t got_data, idx_t exp_idx, word_t exp_data);
    if (got_idx !== exp_idx) begin
      stop_on_error($sformatf("CHECK FAILED at %0t: wgt_idx_o got %0d expected %0d",
                              $time, got_idx, exp_idx));
    end else begin
      check_word("wgt_data_o", got_data, exp_data);
    end
  endtask

  // one access, reply checked one cycle after the request
  task automatic cfg_access(logic we, cfg_reg_e addr, word_t wdata);
    cfg_rsp_t              exp;
    logic [`HWCE_ID_W-1:0] id;
    id          = `HWCE_ID_W'($urandom);
    exp.r_valid = 1'b1;
    exp.r_id    = id;
    exp.r_data  = (addr == REG_STATUS) ? word_t'(job_busy) : shadow[addr];
    @(posedge clk_gated);
    #1;
    cfg_i = '{req: 1'b1, we: we, addr: addr, wdata: wdata, id: id};
    @(posedge clk_gated);
    #1;
    cfg_i.req = 1'b0;
    if (we && !job_busy) begin
      if (addr == REG_TRIGGER) begin
        job_busy = 1'b1;
      end else if (addr == REG_LEN || addr == REG_WGT_LEN) begin
        shadow[addr] = word_t'(wdata[`HWCE_LEN_W-1:0]);
      end else if (addr != REG_STATUS) begin
        shadow[addr] = wdata;
      end
    end
    @(negedge clk_gated);
    check_cfg_rsp(cfg_o, exp);
  endtask

  // mid-cycle view of everything that transfers at the next rising edge
  task automatic sample_outputs();
    rd_pend = 1'b0;
    if (mem_req_o.req && mem_rsp_i.gnt) begin
      if (mem_req_o.we && (mem_req_o.addr < dst_lo || mem_req_o.addr >= dst_hi)) begin
        stop_on_error($sformatf("memory write to %h lies outside the destination block",
                                mem_req_o.addr));
      end else if (mem_req_o.we) begin
        mem_model[mem_req_o.addr] = mem_req_o.wdata;
      end else begin
        rd_pend = 1'b1;
        rd_addr = mem_req_o.addr;
      end
    end
    if (out_valid_o && out_ready_i) begin
      if (exp_out.size() == 0) begin
        stop_on_error("output stream carried more words than the block length");
      end else begin
        check_word("out_data_o", out_data_o, exp_out.pop_front());
      end
    end
    if (wgt_valid_o) begin
      if (wgt_cnt >= exp_wgt.size()) begin
        stop_on_error("weight strobe beyond the weight block length");
      end else begin
        check_weight(wgt_idx_o, wgt_data_o, idx_t'(wgt_cnt), exp_wgt[wgt_cnt]);
        wgt_cnt++;
      end
    end
    if (in_valid_i && in_ready_o) begin
      in_took = 1'b1;
      in_idx++;
    end
    if (evt_o) begin
      evt_cnt++;
      job_busy = 1'b0;
    end
    // busy from the cycle after the trigger up to the event cycle
    check_bit("busy_o", busy_o, job_busy);
    if (i_dut.i_checker.fail_cnt != 0) begin
      stop_on_error("a protocol assertion on the DUT ports failed");
    end
  endtask

  // memory responder, stream partners and output monitor
  initial begin
    mem_rsp_i   = '0;
    out_ready_i = 1'b0;
    in_valid_i  = 1'b0;
    in_data_i   = '0;
    in_took     = 1'b0;
    rd_pend     = 1'b0;
    rd_addr     = '0;
    evt_cnt     = 0;
    forever begin
      @(posedge clk_gated);
      #1;
      mem_rsp_i.r_valid = rd_pend;
      mem_rsp_i.r_data  = rd_pend ? mem_read(rd_addr) : word_t'($urandom);
      mem_rsp_i.gnt     = ($urandom_range(0, 3) != 0);
      out_ready_i       = !stall_out && ($urandom_range(0, 2) != 0);
      // valid holds with the same word until it is taken
      if (in_took || !in_valid_i) begin
        in_valid_i = 1'b0;
        if (in_idx < in_words.size() && $urandom_range(0, 1) == 1) begin
          in_valid_i = 1'b1;
          in_data_i  = in_words[in_idx];
        end
      end
      in_took = 1'b0;
      @(negedge clk_gated);
      sample_outputs();
    end
  end

  task automatic run_job(int job_no);
    int unsigned len;
    int unsigned wlen;
    addr_t       src_base;
    addr_t       dst_base;
    addr_t       wgt_base;
    int          waited;
    len      = $urandom_range(1, 12);
    wlen     = (job_no % 4 == 3) ? 0 : $urandom_range(1, 12);
    src_base = 32'h1000_0000 + ($urandom_range(0, 255) << 2);
    dst_base = 32'h2000_0000 + ($urandom_range(0, 255) << 2);
    wgt_base = 32'h3000_0000 + ($urandom_range(0, 255) << 2);
    cfg_access(1'b1, REG_SRC_BASE, src_base);
    cfg_access(1'b1, REG_DST_BASE, dst_base);
    cfg_access(1'b1, REG_LEN, word_t'(len));
    cfg_access(1'b1, REG_WGT_BASE, wgt_base);
    cfg_access(1'b1, REG_WGT_LEN, word_t'(wlen));
    exp_out.delete();
    exp_wgt.delete();
    in_words.delete();
    for (int unsigned i = 0; i < len; i++) begin
      exp_out.push_back(mem_read(src_base + 4 * i));
      in_words.push_back(word_t'($urandom));
    end
    for (int unsigned i = 0; i < wlen; i++) begin
      exp_wgt.push_back(mem_read(wgt_base + 4 * i));
    end
    in_idx    = 0;
    wgt_cnt   = 0;
    dst_lo    = dst_base;
    dst_hi    = dst_base + 4 * len;
    // output held back so the job is surely still running for the next writes
    stall_out = 1'b1;
    cfg_access(1'b1, REG_TRIGGER, '0);
    cfg_access(1'b0, REG_STATUS, '0);
    cfg_access(1'b1, REG_TRIGGER, '0);
    cfg_access(1'b1, REG_LEN, 32'h0000_ffff);
    stall_out = 1'b0;
    waited    = 0;
    while (job_busy && waited < WAIT_MAX) begin
      @(negedge clk_gated);
      waited++;
    end
    if (job_busy) begin
      stop_on_error($sformatf("timeout waiting for evt_o at the end of job %0d", job_no));
    end else if (exp_out.size() != 0 || wgt_cnt != int'(wlen) || in_idx != int'(len)) begin
      stop_on_error($sformatf("job %0d ended with words still missing", job_no));
    end else if (evt_cnt != job_no + 1) begin
      stop_on_error($sformatf("saw %0d evt_o pulses after %0d jobs", evt_cnt, job_no + 1));
    end
    for (int unsigned i = 0; i < len; i++) begin
      check_word($sformatf("memory word %h", dst_base + 4 * i),
                 mem_read(dst_base + 4 * i), in_words[i]);
    end
    cfg_access(1'b0, REG_STATUS, '0);
    cfg_access(1'b0, REG_LEN, '0);
  endtask

  initial begin
    void'($urandom(32'h78b9));
    rst_n     = 1'b0;
    cfg_i     = '0;
    stall_out = 1'b0;
    job_busy  = 1'b0;
    in_idx    = 0;
    wgt_cnt   = 0;
    dst_lo    = '0;
    dst_hi    = '0;
    shadow    = '{default: '0};
    repeat (2) @(posedge clk_gated);
    #1;
    rst_n = 1'b1;
    // register readback
    for (int r = REG_SRC_BASE; r <= REG_WGT_LEN; r++) begin
      cfg_access(1'b1, cfg_reg_e'(r), word_t'($urandom));
      cfg_access(1'b0, cfg_reg_e'(r), '0);
    end
    cfg_access(1'b0, REG_STATUS, '0);
    for (int j = 0; j < N_JOBS; j++) begin
      run_job(j);
    end
    // idle tail to catch a late extra event
    repeat (20) @(negedge clk_gated);
    if (evt_cnt != N_JOBS) begin
      stop_on_error($sformatf("saw %0d evt_o pulses for %0d jobs", evt_cnt, N_JOBS));
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

/* vlog.f */
+incdir+logic
logic/hwce_pkg.sv
logic/hwce_job_ctrl.sv
logic/hwce_weight_loader.sv
logic/hwce_stream_source.sv
logic/hwce_stream_sink.sv
logic/hwce_tcdm_arbiter.sv
logic/hwce_top.sv
tests/hwce_checker.sv
tests/hwce_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module hwce_tb -f vlog.f
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

sim_out=$(./obj_dir/Vhwce_tb 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "TESTS PASSED"; then
  exit 0
fi
exit 1
